/* design/gfx_soc_pkg.sv */
// Graphics SoC bus definitions
`default_nettype none

package gfx_soc_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = 4;

	typedef enum logic [1:0] {
		okay   = 2'b00,
		slverr = 2'b10,
		decerr = 2'b11
	} axil_resp_e;

	// Master driven half of an AXI-Lite port
	typedef struct packed {
		logic [addr_w-1:0] awaddr;
		logic              awvalid;
		logic [data_w-1:0] wdata;
		logic [strb_w-1:0] wstrb;
		logic              wvalid;
		logic              bready;
		logic [addr_w-1:0] araddr;
		logic              arvalid;
		logic              rready;
	} axil_req_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		axil_resp_e        bresp;
		logic              bvalid;
		logic              arready;
		logic [data_w-1:0] rdata;
		axil_resp_e        rresp;
		logic              rvalid;
	} axil_rsp_t;

	// Fill engine register map, byte offsets
	typedef enum logic [3:0] {
		reg_base  = 4'h0,
		reg_count = 4'h4,
		reg_color = 4'h8,
		reg_ctrl  = 4'hC  // Bit 0 start on write, busy/done on read
	} fill_reg_e;

	typedef enum logic [1:0] {xb_idle, xb_write, xb_read, xb_respond} xbar_state_e;

	typedef enum logic [1:0] {fill_idle, fill_issue, fill_wait_resp} fill_state_e;

endpackage

`default_nettype wire

/* design/axil_crossbar.sv */
// AXI-Lite crossbar, two masters and two slaves
`timescale 1ns/1ps
`default_nettype none

module axil_crossbar #(
	parameter logic [gfx_soc_pkg::addr_w-1:0] mem_base = 32'h0000_0000,
	parameter int mem_win_bits = 12,
	parameter logic [gfx_soc_pkg::addr_w-1:0] gfx_base = 32'h0001_0000,
	parameter int gfx_win_bits = 4
) (
	input  wire                              hdmi_pixClk,
	input  wire                              rst_n,
	input  wire gfx_soc_pkg::axil_req_t [1:0] m_req,
	output gfx_soc_pkg::axil_rsp_t [1:0]      m_rsp,
	output gfx_soc_pkg::axil_req_t [1:0]      s_req,
	input  wire gfx_soc_pkg::axil_rsp_t [1:0] s_rsp
);
	import gfx_soc_pkg::*;

	xbar_state_e state;
	logic grant;    // Master that owns the path
	logic sel;      // 0 memory, 1 fill registers
	logic dec_err;
	logic is_wr;
	logic rr_ptr;   // Master with priority in the next arbitration
	logic aw_seen;
	logic w_seen;

	logic [1:0] m_any;
	logic pick;
	logic pick_wr;
	logic pick_sel;
	logic pick_err;
	logic [addr_w-1:0] pick_addr;
	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic resp_hs;

	function automatic logic win_hit(
		input logic [addr_w-1:0] addr,
		input logic [addr_w-1:0] base,
		input int bits
	);
		return (addr >> bits) == (base >> bits);
	endfunction

	// Arbitration and decode of the candidate request
	always_comb begin
		m_any[0] = m_req[0].awvalid | m_req[0].arvalid;
		m_any[1] = m_req[1].awvalid | m_req[1].arvalid;
		pick = m_any[rr_ptr] ? rr_ptr : ~rr_ptr;
		pick_wr = m_req[pick].awvalid;  // Writes win over reads
		pick_addr = pick_wr ? m_req[pick].awaddr : m_req[pick].araddr;
		pick_sel = win_hit(pick_addr, gfx_base, gfx_win_bits);
		pick_err = !win_hit(pick_addr, mem_base, mem_win_bits) && !pick_sel;
	end

	always_comb begin
		m_rsp = '0;
		s_req = '0;
		aw_hs = 1'b0;
		w_hs = 1'b0;
		ar_hs = 1'b0;
		resp_hs = 1'b0;
		case (state)
		xb_write: begin
			if (!dec_err) begin
				s_req[sel].awaddr = m_req[grant].awaddr;
				s_req[sel].awvalid = m_req[grant].awvalid & ~aw_seen;
				s_req[sel].wdata = m_req[grant].wdata;
				s_req[sel].wstrb = m_req[grant].wstrb;
				s_req[sel].wvalid = m_req[grant].wvalid & ~w_seen;
				m_rsp[grant].awready = s_rsp[sel].awready & ~aw_seen;
				m_rsp[grant].wready = s_rsp[sel].wready & ~w_seen;
			end else begin
				m_rsp[grant].awready = ~aw_seen;  // Swallow the unmapped write
				m_rsp[grant].wready = ~w_seen;
			end
			aw_hs = m_req[grant].awvalid & m_rsp[grant].awready;
			w_hs = m_req[grant].wvalid & m_rsp[grant].wready;
		end
		xb_read: begin
			if (!dec_err) begin
				s_req[sel].araddr = m_req[grant].araddr;
				s_req[sel].arvalid = m_req[grant].arvalid;
				m_rsp[grant].arready = s_rsp[sel].arready;
			end else begin
				m_rsp[grant].arready = 1'b1;
			end
			ar_hs = m_req[grant].arvalid & m_rsp[grant].arready;
		end
		xb_respond: begin
			if (is_wr) begin
				if (!dec_err) begin
					s_req[sel].bready = m_req[grant].bready;
					m_rsp[grant].bvalid = s_rsp[sel].bvalid;
					m_rsp[grant].bresp = s_rsp[sel].bresp;
				end else begin
					m_rsp[grant].bvalid = 1'b1;
					m_rsp[grant].bresp = decerr;
				end
				resp_hs = m_rsp[grant].bvalid & m_req[grant].bready;
			end else begin
				if (!dec_err) begin
					s_req[sel].rready = m_req[grant].rready;
					m_rsp[grant].rvalid = s_rsp[sel].rvalid;
					m_rsp[grant].rdata = s_rsp[sel].rdata;
					m_rsp[grant].rresp = s_rsp[sel].rresp;
				end else begin
					m_rsp[grant].rvalid = 1'b1;  // rdata stays zero
					m_rsp[grant].rresp = decerr;
				end
				resp_hs = m_rsp[grant].rvalid & m_req[grant].rready;
			end
		end
		default: ;
		endcase
	end

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			state <= xb_idle;
			grant <= 1'b0;
			sel <= 1'b0;
			dec_err <= 1'b0;
			is_wr <= 1'b0;
			rr_ptr <= 1'b0;
			aw_seen <= 1'b0;
			w_seen <= 1'b0;
		end else begin
			case (state)
			xb_idle: begin
				if (|m_any) begin
					grant <= pick;
					sel <= pick_sel;
					dec_err <= pick_err;
					is_wr <= pick_wr;
					rr_ptr <= ~pick;
					state <= pick_wr ? xb_write : xb_read;
				end
			end
			xb_write: begin
				if ((aw_hs | aw_seen) & (w_hs | w_seen)) begin
					aw_seen <= 1'b0;
					w_seen <= 1'b0;
					state <= xb_respond;
				end else begin
					aw_seen <= aw_seen | aw_hs;
					w_seen <= w_seen | w_hs;
				end
			end
			xb_read: begin
				if (ar_hs)
					state <= xb_respond;
			end
			xb_respond: begin
				if (resp_hs)
					state <= xb_idle;  // Held here by bready/rready
			end
			default: state <= xb_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/axil_memory.sv */
// AXI-Lite word memory
`timescale 1ns/1ps
`default_nettype none

module axil_memory #(
	parameter int mem_words = 1024,
	parameter int mem_win_bits = 12
) (
	input  wire                         hdmi_pixClk,
	input  wire                         rst_n,
	input  wire gfx_soc_pkg::axil_req_t req,
	output gfx_soc_pkg::axil_rsp_t      rsp
);
	import gfx_soc_pkg::*;

	localparam int idx_w = $clog2(mem_words);

	logic [data_w-1:0] mem [mem_words];
	logic [idx_w-1:0] wr_idx;
	logic [idx_w-1:0] rd_idx;
	logic wr_go;
	logic rd_go;
	logic bvalid_q;
	logic rvalid_q;
	logic [data_w-1:0] rdata_q;

	// Word index within the window, wrapped to the depth
	assign wr_idx = idx_w'(req.awaddr[mem_win_bits-1:2] % mem_words);
	assign rd_idx = idx_w'(req.araddr[mem_win_bits-1:2] % mem_words);

	assign wr_go = req.awvalid & req.wvalid & ~bvalid_q;
	assign rd_go = req.arvalid & ~rvalid_q;

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_go) begin
			for (int b = 0; b < strb_w; b++) begin
				if (req.wstrb[b])
					mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
		if (rd_go)
			rdata_q <= mem[rd_idx];
	end

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (req.bready)
				bvalid_q <= 1'b0;
			if (rd_go)
				rvalid_q <= 1'b1;
			else if (req.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_comb begin
		rsp.awready = wr_go;  // Address and data taken together
		rsp.wready = wr_go;
		rsp.bresp = okay;
		rsp.bvalid = bvalid_q;
		rsp.arready = ~rvalid_q;
		rsp.rdata = rdata_q;
		rsp.rresp = okay;
		rsp.rvalid = rvalid_q;
	end

endmodule

`default_nettype wire

/* design/fill_engine.sv */
// Framebuffer fill engine
`timescale 1ns/1ps
`default_nettype none

module fill_engine #(
	parameter int gfx_win_bits = 4
) (
	input  wire                         hdmi_pixClk,
	input  wire                         rst_n,
	input  wire gfx_soc_pkg::axil_req_t cfg_req,
	output gfx_soc_pkg::axil_rsp_t      cfg_rsp,
	output gfx_soc_pkg::axil_req_t      dma_req,
	input  wire gfx_soc_pkg::axil_rsp_t dma_rsp,
	output logic                        irq
);
	import gfx_soc_pkg::*;

	fill_state_e state;
	logic [addr_w-1:0] base_q;
	logic [data_w-1:0] count_q;
	logic [data_w-1:0] color_q;
	logic done;
	logic busy;
	logic [addr_w-1:0] cur_addr;
	logic [data_w-1:0] remain;   // Words still to write
	logic aw_ok;
	logic w_ok;
	logic cfg_bvalid;
	logic cfg_rvalid;
	logic [data_w-1:0] cfg_rdata;
	logic cfg_wr_go;
	logic cfg_rd_go;
	logic [gfx_win_bits-1:0] wr_off;
	logic [gfx_win_bits-1:0] rd_off;
	logic start;
	logic aw_hs;
	logic w_hs;

	function automatic logic [data_w-1:0] merge(
		input logic [data_w-1:0] old,
		input logic [data_w-1:0] val,
		input logic [strb_w-1:0] strb
	);
		logic [data_w-1:0] res;
		res = old;
		for (int b = 0; b < strb_w; b++) begin
			if (strb[b])
				res[8*b +: 8] = val[8*b +: 8];
		end
		return res;
	endfunction

	assign busy = (state != fill_idle);
	assign irq = done;

	assign wr_off = cfg_req.awaddr[gfx_win_bits-1:0];
	assign rd_off = cfg_req.araddr[gfx_win_bits-1:0];
	assign cfg_wr_go = cfg_req.awvalid & cfg_req.wvalid & ~cfg_bvalid;
	assign cfg_rd_go = cfg_req.arvalid & ~cfg_rvalid;
	assign start = cfg_wr_go & ~busy & cfg_req.wdata[0] & (wr_off == gfx_win_bits'(reg_ctrl));

	always_comb begin
		cfg_rsp.awready = cfg_wr_go;
		cfg_rsp.wready = cfg_wr_go;
		cfg_rsp.bresp = okay;
		cfg_rsp.bvalid = cfg_bvalid;
		cfg_rsp.arready = ~cfg_rvalid;
		cfg_rsp.rdata = cfg_rdata;
		cfg_rsp.rresp = okay;
		cfg_rsp.rvalid = cfg_rvalid;
	end

	// Write master, read channel unused
	always_comb begin
		dma_req = '0;
		dma_req.awaddr = cur_addr;
		dma_req.awvalid = (state == fill_issue) & ~aw_ok;
		dma_req.wdata = color_q;
		dma_req.wstrb = '1;
		dma_req.wvalid = (state == fill_issue) & ~w_ok;
		dma_req.bready = (state == fill_wait_resp);
	end

	assign aw_hs = dma_req.awvalid & dma_rsp.awready;
	assign w_hs = dma_req.wvalid & dma_rsp.wready;

	// Register file
	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			base_q <= '0;
			count_q <= '0;
			color_q <= '0;
			cfg_bvalid <= 1'b0;
			cfg_rvalid <= 1'b0;
			cfg_rdata <= '0;
		end else begin
			if (cfg_wr_go) begin
				cfg_bvalid <= 1'b1;
				if (!busy) begin  // Dropped while a fill runs
					case (wr_off)
					gfx_win_bits'(reg_base):  base_q <= merge(base_q, cfg_req.wdata, cfg_req.wstrb);
					gfx_win_bits'(reg_count): count_q <= merge(count_q, cfg_req.wdata, cfg_req.wstrb);
					gfx_win_bits'(reg_color): color_q <= merge(color_q, cfg_req.wdata, cfg_req.wstrb);
					default: ;
					endcase
				end
			end else if (cfg_req.bready) begin
				cfg_bvalid <= 1'b0;
			end
			if (cfg_rd_go) begin
				cfg_rvalid <= 1'b1;
				case (rd_off)
				gfx_win_bits'(reg_base):  cfg_rdata <= base_q;
				gfx_win_bits'(reg_count): cfg_rdata <= count_q;
				gfx_win_bits'(reg_color): cfg_rdata <= color_q;
				gfx_win_bits'(reg_ctrl):  cfg_rdata <= {{(data_w-2){1'b0}}, done, busy};
				default: cfg_rdata <= '0;
				endcase
			end else if (cfg_req.rready) begin
				cfg_rvalid <= 1'b0;
			end
		end
	end

	// Fill FSM, one write in flight
	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			state <= fill_idle;
			done <= 1'b0;
			cur_addr <= '0;
			remain <= '0;
			aw_ok <= 1'b0;
			w_ok <= 1'b0;
		end else begin
			case (state)
			fill_idle: begin
				if (start) begin
					cur_addr <= base_q;
					remain <= count_q;
					done <= (count_q == '0);  // Empty fill finishes at once
					if (count_q != '0)
						state <= fill_issue;
				end
			end
			fill_issue: begin
				if ((aw_hs | aw_ok) & (w_hs | w_ok)) begin
					aw_ok <= 1'b0;
					w_ok <= 1'b0;
					state <= fill_wait_resp;
				end else begin
					aw_ok <= aw_ok | aw_hs;
					w_ok <= w_ok | w_hs;
				end
			end
			fill_wait_resp: begin
				if (dma_rsp.bvalid) begin
					cur_addr <= cur_addr + addr_w'(4);
					remain <= remain - data_w'(1);
					if (remain == data_w'(1)) begin
						done <= 1'b1;
						state <= fill_idle;
					end else begin
						state <= fill_issue;
					end
				end
			end
			default: state <= fill_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/gfx_soc_top.sv */
// Graphics SoC bus subsystem
`timescale 1ns/1ps
`default_nettype none

module gfx_soc_top #(
	parameter int mem_words = 1024,
	parameter logic [gfx_soc_pkg::addr_w-1:0] mem_base = 32'h0000_0000,
	parameter int mem_win_bits = 12,
	parameter logic [gfx_soc_pkg::addr_w-1:0] gfx_base = 32'h0001_0000,
	parameter int gfx_win_bits = 4
) (
	input  wire                         hdmi_pixClk,
	input  wire                         rst_n,
	input  wire gfx_soc_pkg::axil_req_t host_req,
	output gfx_soc_pkg::axil_rsp_t      host_rsp,
	output logic                        irq
);
	import gfx_soc_pkg::*;

	wire axil_req_t [1:0] mst_req;  // Host on 0, fill engine on 1
	wire axil_rsp_t [1:0] mst_rsp;
	wire axil_req_t [1:0] slv_req;  // Memory on 0, fill registers on 1
	wire axil_rsp_t [1:0] slv_rsp;

	assign mst_req[0] = host_req;
	assign host_rsp = mst_rsp[0];

	axil_crossbar #(
		.mem_base(mem_base),
		.mem_win_bits(mem_win_bits),
		.gfx_base(gfx_base),
		.gfx_win_bits(gfx_win_bits)
	) AxiCrossbar (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.m_req(mst_req),
		.m_rsp(mst_rsp),
		.s_req(slv_req),
		.s_rsp(slv_rsp)
	);

	axil_memory #(
		.mem_words(mem_words),
		.mem_win_bits(mem_win_bits)
	) Memory (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.req(slv_req[0]),
		.rsp(slv_rsp[0])
	);

	fill_engine #(
		.gfx_win_bits(gfx_win_bits)
	) FillEngine (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.cfg_req(slv_req[1]),
		.cfg_rsp(slv_rsp[1]),
		.dma_req(mst_req[1]),
		.dma_rsp(mst_rsp[1]),
		.irq(irq)
	);

endmodule

`default_nettype wire

/* verification/tb_axil_host.svh */
// Host bus tasks
`ifndef TB_AXIL_HOST_SVH
`define TB_AXIL_HOST_SVH

logic [31:0] rng_state = 32'h54321eb2;

// xorshift32
function automatic logic [31:0] rand_next();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		$display("MISMATCH %s expected %08h actual %08h", name, exp, act);
		$display("TEST FAIL");
		$fatal(1);
	end
endtask

// Address and data raised together, each dropped after its own handshake
task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
	logic aw_pend;
	logic w_pend;
	logic aw_take;
	logic w_take;
	@(posedge hdmi_pixClk);
	host_req.awaddr <= addr;
	host_req.awvalid <= 1'b1;
	host_req.wdata <= data;
	host_req.wstrb <= strb;
	host_req.wvalid <= 1'b1;
	host_req.bready <= 1'b1;
	aw_pend = 1'b1;
	w_pend = 1'b1;
	while (aw_pend || w_pend) begin
		@(negedge hdmi_pixClk);
		aw_take = aw_pend & host_rsp.awready;
		w_take = w_pend & host_rsp.wready;
		@(posedge hdmi_pixClk);
		if (aw_take) begin
			host_req.awvalid <= 1'b0;
			aw_pend = 1'b0;
		end
		if (w_take) begin
			host_req.wvalid <= 1'b0;
			w_pend = 1'b0;
		end
	end
	@(negedge hdmi_pixClk);
	while (!host_rsp.bvalid)
		@(negedge hdmi_pixClk);
	resp = host_rsp.bresp;
	@(posedge hdmi_pixClk);
	host_req.bready <= 1'b0;  // B handshake on this edge
endtask

task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
	logic ar_take;
	@(posedge hdmi_pixClk);
	host_req.araddr <= addr;
	host_req.arvalid <= 1'b1;
	host_req.rready <= 1'b1;
	ar_take = 1'b0;
	while (!ar_take) begin
		@(negedge hdmi_pixClk);
		ar_take = host_rsp.arready;
		@(posedge hdmi_pixClk);
	end
	host_req.arvalid <= 1'b0;
	@(negedge hdmi_pixClk);
	while (!host_rsp.rvalid)
		@(negedge hdmi_pixClk);
	data = host_rsp.rdata;
	resp = host_rsp.rresp;
	@(posedge hdmi_pixClk);
	host_req.rready <= 1'b0;
endtask

`endif

/* verification/tb_gfx_soc.sv */
// Graphics SoC testbench
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_soc;
	import gfx_soc_pkg::*;

	localparam int mem_words = 1024;
	localparam logic [31:0] gfx_base = 32'h0001_0000;
	localparam int n_rand = 64;
	localparam int n_fills = 8;
	localparam int max_fill = 40;
	localparam int big_fill = 200;
	localparam int n_cont = 16;
	localparam logic [31:0] host_area = 32'h0000_0800;  // Clear of the big fill
	localparam int n_ops = mem_words + 2 * n_rand + 16 + n_fills * (2 * (max_fill + 1) + 8)
		+ 3 * n_cont + 2 * (big_fill + 4) + 12;
	localparam int n_words = n_fills * max_fill + big_fill + 1;
	localparam int limit_cycles = 200 * n_ops + 4 * n_words;

	logic hdmi_pixClk;
	logic rst_n;
	axil_req_t host_req;
	axil_rsp_t host_rsp;
	logic irq;

	logic [31:0] shadow [mem_words];  // Expected memory contents
	logic [31:0] rand_addr [n_rand];

	`include "tb_axil_host.svh"

	gfx_soc_top #(
		.mem_words(mem_words),
		.mem_base(32'h0000_0000),
		.mem_win_bits(12),
		.gfx_base(gfx_base),
		.gfx_win_bits(4)
	) UUT (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.irq(irq)
	);

	function automatic logic [31:0] exp_fill_word(input int idx, input logic [31:0] base,
			input int count, input logic [31:0] color, input logic [31:0] prior);
		int first;
		first = int'(base >> 2);
		if (idx >= first && idx < first + count)
			return color;
		return prior;
	endfunction

	function automatic logic [31:0] apply_strobe(input logic [31:0] old,
			input logic [31:0] val, input logic [3:0] strb);
		logic [31:0] res;
		for (int b = 0; b < 4; b++)
			res[8*b +: 8] = strb[b] ? val[8*b +: 8] : old[8*b +: 8];
		return res;
	endfunction

	task automatic start_fill(input logic [31:0] base, input int count, input logic [31:0] color);
		logic [1:0] resp;
		write_word(gfx_base + 32'(reg_base), base, 4'hf, resp);
		write_word(gfx_base + 32'(reg_count), 32'(count), 4'hf, resp);
		write_word(gfx_base + 32'(reg_color), color, 4'hf, resp);
		write_word(gfx_base + 32'(reg_ctrl), 32'd1, 4'hf, resp);
		check_value("fill start resp", 32'(okay), 32'(resp));
		if (count != 0) begin
			@(negedge hdmi_pixClk);
			check_value("irq cleared by start", 32'd0, 32'(irq));
		end
	endtask

	task automatic wait_fill_done();
		logic [31:0] ctrl;
		logic [1:0] resp;
		ctrl = '0;
		while (!ctrl[1])
			read_word(gfx_base + 32'(reg_ctrl), ctrl, resp);
		check_value("busy at done", 32'd0, 32'(ctrl[0]));
		@(negedge hdmi_pixClk);
		check_value("irq at done", 32'd1, 32'(irq));
	endtask

	// Region plus two words either side
	task automatic verify_fill(input logic [31:0] base, input int count,
			input logic [31:0] color, input string name);
		logic [31:0] data;
		logic [31:0] expected;
		logic [1:0] resp;
		int first;
		first = int'(base >> 2);
		for (int i = first - 2; i < first + count + 2; i++) begin
			read_word(32'(i) << 2, data, resp);
			expected = exp_fill_word(i, base, count, color, shadow[i]);
			check_value(name, expected, data);
			check_value(name, 32'(okay), 32'(resp));
			shadow[i] = expected;
		end
	endtask

	initial begin
		hdmi_pixClk = 1'b0;
		forever #5 hdmi_pixClk = ~hdmi_pixClk;
	end

	initial begin
		repeat (limit_cycles) @(posedge hdmi_pixClk);
		$display("Timeout after %0d cycles, a bus transfer or fill never completed", limit_cycles);
		$display("TEST FAIL");
		$fatal(1);
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] tmp;
		logic [31:0] color;
		logic [31:0] reg_val [3];
		logic [3:0] strb;
		logic [1:0] resp;
		int first;
		int count;
		int n_done;
		host_req <= '0;
		rst_n <= 1'b0;
		repeat (8) @(posedge hdmi_pixClk);
		rst_n <= 1'b1;

		// Known contents everywhere with full strobes
		for (int k = 0; k < mem_words; k++) begin
			shadow[k] = (32'(k) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
			write_word(32'(k) << 2, shadow[k], 4'hf, resp);
		end

		for (int k = 0; k < n_rand; k++) begin
			addr = rand_next() & 32'h0000_0ffc;
			data = rand_next();
			tmp = rand_next();
			strb = tmp[3:0];
			rand_addr[k] = addr;
			write_word(addr, data, strb, resp);
			check_value("memory write resp", 32'(okay), 32'(resp));
			shadow[addr[11:2]] = apply_strobe(shadow[addr[11:2]], data, strb);
		end
		for (int k = 0; k < n_rand; k++) begin
			read_word(rand_addr[k], data, resp);
			check_value("memory readback", shadow[rand_addr[k][11:2]], data);
			check_value("memory read resp", 32'(okay), 32'(resp));
		end

		for (int k = 0; k < 2; k++) begin
			addr = (k == 0) ? 32'h0002_0000 : 32'h8000_0000;
			write_word(addr, 32'hdead_beef, 4'hf, resp);
			check_value("decode error write resp", 32'(decerr), 32'(resp));
			read_word(addr, data, resp);
			check_value("decode error read resp", 32'(decerr), 32'(resp));
			check_value("decode error read data", 32'd0, data);
		end
		for (int k = 0; k < 4; k++) begin
			read_word(32'(k) << 2, data, resp);
			check_value("memory after decode error", shadow[k], data);
		end

		@(negedge hdmi_pixClk);
		check_value("irq after reset", 32'd0, 32'(irq));
		for (int k = 0; k < 4; k++) begin
			read_word(gfx_base + 32'(k) * 4, data, resp);
			check_value("register after reset", 32'd0, data);
		end
		for (int k = 0; k < 3; k++) begin
			reg_val[k] = rand_next();
			write_word(gfx_base + 32'(k) * 4, reg_val[k], 4'hf, resp);
			check_value("register write resp", 32'(okay), 32'(resp));
		end
		for (int k = 0; k < 3; k++) begin
			read_word(gfx_base + 32'(k) * 4, data, resp);
			check_value("register readback", reg_val[k], data);
		end

		for (int k = 0; k < n_fills; k++) begin
			tmp = rand_next();
			first = 2 + int'(tmp % 32'(mem_words - max_fill - 4));
			tmp = rand_next();
			count = (k == 0) ? 0 : int'(tmp % 32'(max_fill + 1));  // Empty fill first
			color = rand_next();
			start_fill(32'(first) << 2, count, color);
			wait_fill_done();
			verify_fill(32'(first) << 2, count, color, "fill region");
		end

		// Host traffic while the long fill runs
		color = rand_next();
		start_fill(32'h0000_0020, big_fill, color);
		n_done = 0;
		read_word(gfx_base + 32'(reg_ctrl), tmp, resp);
		while (tmp[0] && n_done < n_cont) begin
			addr = host_area + (32'(n_done) << 2);
			data = rand_next();
			write_word(addr, data, 4'hf, resp);
			check_value("contention write resp", 32'(okay), 32'(resp));
			shadow[addr[11:2]] = data;
			read_word(addr, data, resp);
			check_value("contention host read", shadow[addr[11:2]], data);
			read_word(gfx_base + 32'(reg_ctrl), tmp, resp);
			n_done++;
		end
		if (n_done == 0) begin
			$display("Fill engine was idle before any host transfer could overlap it");
			$display("TEST FAIL");
			$fatal(1);
		end
		wait_fill_done();
		verify_fill(32'h0000_0020, big_fill, color, "contention fill region");
		for (int k = 0; k < n_done; k++) begin
			addr = host_area + (32'(k) << 2);
			read_word(addr, data, resp);
			check_value("host area after fill", shadow[addr[11:2]], data);
		end

		color = rand_next();
		start_fill(32'h0000_0c00, 1, color);
		wait_fill_done();
		verify_fill(32'h0000_0c00, 1, color, "last fill region");

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verification
design/gfx_soc_pkg.sv
design/axil_crossbar.sv
design/axil_memory.sv
design/fill_engine.sv
design/gfx_soc_top.sv
verification/tb_gfx_soc.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_gfx_soc
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
